//--- Makefile
TOP = noise_tb

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f all.f -o sim
	./obj_dir/sim | tee sim.log
	@grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: help test clean

//--- all.f
+incdir+dv
design/noise_pkg.sv
design/prbs_bank.sv
design/noise_registers.sv
design/burst_sequencer.sv
design/noise_generator.sv
dv/noise_tb.sv

//--- design/burst_sequencer.sv
`timescale 1ns/1ps

module burst_sequencer import noise_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        trigger,
    input  count_t      burst_length,
    input  dest_table_t dest_table,
    input  index_t      index,
    output logic        advance,
    output noise_beat_t beat,
    output logic        beat_valid,
    input  logic        beat_ready
);

    seq_state_t  state;
    count_t      length_latched;
    count_t      beat_count;      // beats loaded so far.
    sample_t     sample_table [TABLE_DEPTH];
    logic        start;
    logic        load;
    logic        final_accept;
    count_t      load_index;
    count_t      load_length;
    noise_beat_t beat_next;

    initial begin
        $readmemh("erf.mem", sample_table);
    end

    ////////////////////
    // load decision
    ////////////////////

    assign start = (state == idle) && trigger && (burst_length != '0);
    assign load = start ||
                  ((state == working) && (beat_count != length_latched) &&
                   (!beat_valid || beat_ready));
    assign final_accept = (state == working) && beat_valid && beat_ready && beat.last;
    assign advance = load;  // one generator step per loaded beat.

    // the first beat is loaded on the trigger edge itself.
    assign load_index = (state == idle) ? '0 : beat_count;
    assign load_length = (state == idle) ? burst_length : length_latched;

    always_comb begin
        beat_next.sample = sample_table[index];
        beat_next.dest = dest_table[load_index[3:0]];
        beat_next.last = (load_index == count_t'(load_length - count_t'(1)));
    end

    ////////////////////
    // state and counters
    ////////////////////

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= idle;
            length_latched <= '0;
            beat_count <= '0;
            beat_valid <= 1'b0;
        end else begin
            if (start) begin
                state <= working;
                length_latched <= burst_length;
            end else if (final_accept) begin
                state <= idle;
            end
            if (load) begin
                beat_count <= count_t'(load_index + count_t'(1));
                beat_valid <= 1'b1;
            end else if (beat_ready) begin
                beat_valid <= 1'b0;  // drained.
            end
        end
    end

    // output beat holds while stalled.
    always_ff @(posedge clock) begin
        if (load) begin
            beat <= beat_next;
        end
    end

endmodule

//--- design/noise_generator.sv
`timescale 1ns/1ps

module noise_generator import noise_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         trigger,
    input  reg_address_t reg_address,
    input  logic         reg_write,
    input  reg_data_t    reg_write_data,
    output reg_data_t    reg_read_data,
    output noise_beat_t  beat,
    output logic         beat_valid,
    input  logic         beat_ready
);

    count_t      burst_length;
    dest_table_t dest_table;
    logic        advance;
    index_t      index;

    noise_registers u_registers (
        .clock          (clock),
        .reset          (reset),
        .reg_address    (reg_address),
        .reg_write      (reg_write),
        .reg_write_data (reg_write_data),
        .reg_read_data  (reg_read_data),
        .burst_length   (burst_length),
        .dest_table     (dest_table)
    );

    prbs_bank u_prbs_bank (
        .clock   (clock),
        .reset   (reset),
        .advance (advance),
        .index   (index)
    );

    burst_sequencer u_sequencer (
        .clock        (clock),
        .reset        (reset),
        .trigger      (trigger),
        .burst_length (burst_length),
        .dest_table   (dest_table),
        .index        (index),
        .advance      (advance),
        .beat         (beat),
        .beat_valid   (beat_valid),
        .beat_ready   (beat_ready)
    );

endmodule

//--- design/noise_pkg.sv
package noise_pkg;

    ////////////////////
    // sizes and constants
    ////////////////////

    localparam int N_GENERATORS = 6;
    localparam int LFSR_WIDTH = 21;
    localparam int FEEDBACK_TAP = 18;          // xored with the top bit.
    localparam int MAX_BEATS = 16;
    localparam int TABLE_DEPTH = 2 ** N_GENERATORS;
    localparam int SAMPLE_WIDTH = 16;
    localparam int DEST_WIDTH = 4;
    localparam int LENGTH_ADDRESS = 0;
    localparam int DEST_BASE_ADDRESS = 1;      // slot 0 sits here.

    ////////////////////
    // types
    ////////////////////

    typedef logic [LFSR_WIDTH-1:0] lfsr_state_t;
    typedef logic [N_GENERATORS-1:0] index_t;  // bit i from generator i.
    typedef logic [SAMPLE_WIDTH-1:0] sample_t;
    typedef logic [DEST_WIDTH-1:0] dest_t;
    typedef logic [4:0] count_t;               // 0 to MAX_BEATS.
    typedef dest_t [MAX_BEATS-1:0] dest_table_t;
    typedef logic [4:0] reg_address_t;
    typedef logic [15:0] reg_data_t;

    localparam lfsr_state_t GENERATOR_SEEDS [N_GENERATORS] = '{
        21'h010101,
        21'h002040,
        21'h014004,
        21'h000c00,
        21'h020008,
        21'h100880
    };

    typedef struct packed {
        sample_t sample;
        dest_t   dest;
        logic    last;
    } noise_beat_t;

    typedef enum logic {
        idle,
        working
    } seq_state_t;

endpackage

//--- design/noise_registers.sv
`timescale 1ns/1ps

module noise_registers import noise_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  reg_address_t reg_address,
    input  logic         reg_write,
    input  reg_data_t    reg_write_data,
    output reg_data_t    reg_read_data,
    output count_t       burst_length,
    output dest_table_t  dest_table
);

    localparam int SLOT_BITS = $clog2(MAX_BEATS);

    count_t               length_next;
    dest_table_t          table_next;
    logic                 length_hit;
    logic                 slot_hit;
    logic [SLOT_BITS-1:0] slot;

    assign length_hit = (reg_address == reg_address_t'(LENGTH_ADDRESS));
    assign slot_hit = (reg_address >= reg_address_t'(DEST_BASE_ADDRESS)) &&
                      (reg_address < reg_address_t'(DEST_BASE_ADDRESS + MAX_BEATS));
    assign slot = SLOT_BITS'(reg_address - reg_address_t'(DEST_BASE_ADDRESS));

    ////////////////////
    // write path
    ////////////////////

    always_comb begin
        length_next = burst_length;
        table_next = dest_table;
        if (reg_write) begin
            if (length_hit) begin
                if (reg_write_data > reg_data_t'(MAX_BEATS)) begin
                    length_next = count_t'(MAX_BEATS);  // saturate.
                end else begin
                    length_next = count_t'(reg_write_data);
                end
            end else if (slot_hit) begin
                table_next[slot] = dest_t'(reg_write_data);  // low bits only.
            end
        end
    end

    // readback uses the post-write values, so a write is seen at once.
    always_ff @(posedge clock) begin
        if (!reset) begin
            burst_length <= '0;
            dest_table <= '0;
            reg_read_data <= '0;
        end else begin
            burst_length <= length_next;
            dest_table <= table_next;
            if (length_hit) begin
                reg_read_data <= reg_data_t'(length_next);
            end else if (slot_hit) begin
                reg_read_data <= reg_data_t'(table_next[slot]);
            end else begin
                reg_read_data <= '0;  // unmapped.
            end
        end
    end

endmodule

//--- design/prbs_bank.sv
`timescale 1ns/1ps

module prbs_bank import noise_pkg::*; (
    input  logic   clock,
    input  logic   reset,
    input  logic   advance,
    output index_t index
);

    lfsr_state_t state [N_GENERATORS];

    ////////////////////
    // generator states
    ////////////////////

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < N_GENERATORS; i++) begin
                state[i] <= GENERATOR_SEEDS[i];
            end
        end else if (advance) begin
            for (int i = 0; i < N_GENERATORS; i++) begin
                state[i] <= {state[i][LFSR_WIDTH-2:0],
                             state[i][LFSR_WIDTH-1] ^ state[i][FEEDBACK_TAP]};
            end
        end
    end

    // one output bit per generator.
    always_comb begin
        for (int i = 0; i < N_GENERATORS; i++) begin
            index[i] = state[i][LFSR_WIDTH-1];
        end
    end

endmodule

//--- dv/noise_tb_model.svh
lfsr_state_t model_state [N_GENERATORS];
sample_t     model_samples [64];
dest_t       model_dests [MAX_BEATS];
int          length_config;

////////////////////
// register model
////////////////////

function automatic void model_write(input int address, input reg_data_t data);
    if (address == 0) begin
        length_config = (data > 16) ? 16 : int'(data);  // saturates at 16.
    end else if (address >= 1 && address <= 16) begin
        model_dests[address - 1] = data[3:0];
    end
endfunction

function automatic void reset_model();
    length_config = 0;
    for (int i = 0; i < N_GENERATORS; i++) begin
        model_state[i] = GENERATOR_SEEDS[i];
    end
    for (int s = 0; s < MAX_BEATS; s++) begin
        model_dests[s] = '0;
    end
endfunction

////////////////////
// generator model
////////////////////

// feedback is bit 20 xor bit 18, shifted in at bit 0.
function automatic void advance_model();
    for (int i = 0; i < N_GENERATORS; i++) begin
        model_state[i] = {model_state[i][19:0], model_state[i][20] ^ model_state[i][18]};
    end
endfunction

function automatic noise_beat_t expected_beat(input int k, input int length);
    noise_beat_t value;
    index_t      index;
    for (int i = 0; i < N_GENERATORS; i++) begin
        index[i] = model_state[i][20];  // top bit of generator i.
    end
    value.sample = model_samples[index];
    value.dest = model_dests[k];
    value.last = (k == length - 1);
    return value;
endfunction

//--- dv/noise_tb.sv
`timescale 1ns/1ps

module noise_tb import noise_pkg::*; ();

    logic         clock;
    logic         reset;
    logic         trigger;
    reg_address_t reg_address;
    logic         reg_write;
    reg_data_t    reg_write_data;
    reg_data_t    reg_read_data;
    noise_beat_t  beat;
    logic         beat_valid;
    logic         beat_ready;

    logic [31:0]  stim_rng;
    logic [31:0]  ready_rng;
    logic         random_ready;
    logic         held;            // beat stalled at the last sample.
    noise_beat_t  held_beat;
    int           beats_pending;
    int           burst_length_model;
    int           check_count;
    int           error_count;

    `include "noise_tb_model.svh"

    noise_generator DUT (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // fibonacci lfsr with taps 32 22 2 1.
    function automatic logic [31:0] random_bits(inout logic [31:0] state, input int n);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < n; i++) begin
            feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
            state = {state[30:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    always @(posedge clock) begin
        beat_ready <= random_ready ? (random_bits(ready_rng, 1) != 32'd0) : 1'b1;
    end

    ////////////////////
    // tasks
    ////////////////////

    task automatic finish_run();
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    task automatic apply_reset();
        @(posedge clock);
        reset <= 1'b0;
        repeat (4) @(posedge clock);
        reset <= 1'b1;
        reset_model();
    endtask

    task automatic write_register(input int address, input reg_data_t data);
        @(posedge clock);
        reg_address <= reg_address_t'(address);
        reg_write <= 1'b1;
        reg_write_data <= data;
        @(posedge clock);
        reg_write <= 1'b0;
        model_write(address, data);
    endtask

    task automatic read_check(input int address, input reg_data_t expected);
        @(posedge clock);
        reg_address <= reg_address_t'(address);
        @(posedge clock);
        @(negedge clock);  // data follows the address by one cycle.
        check_count++;
        if (reg_read_data !== expected) begin
            $display("FAILED at %0d ns: reg_read_data = %h, expected %h", $time,
                     reg_read_data, expected);
            error_count++;
        end
    endtask

    task automatic configure_burst();
        int length;
        length = int'(random_bits(stim_rng, 4)) + 1;
        write_register(0, reg_data_t'(length));
        for (int s = 0; s < length; s++) begin
            write_register(s + 1, reg_data_t'(random_bits(stim_rng, 16)));
        end
    endtask

    task automatic pulse_trigger();
        @(posedge clock);
        trigger <= 1'b1;
        @(posedge clock);
        trigger <= 1'b0;
    endtask

    task automatic wait_burst_done();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while ((beats_pending != 0 || beat_valid) && cycles < 400) begin
            @(negedge clock);
            cycles++;
        end
        if (beats_pending != 0 || beat_valid) begin
            $display("timeout: burst still running after %0d cycles", cycles);
            error_count++;
            finish_run();
        end
    endtask

    task automatic check_no_beat(input int cycles);
        check_count++;
        for (int c = 0; c < cycles; c++) begin
            @(negedge clock);
            if (beat_valid !== 1'b0) begin
                $display("FAILED at %0d ns: beat_valid = %b, expected 0", $time, beat_valid);
                error_count++;
            end
        end
    endtask

    task automatic run_burst(input logic extra_trigger);
        repeat (int'(random_bits(stim_rng, 3))) @(posedge clock);
        burst_length_model = length_config;
        beats_pending = length_config;
        pulse_trigger();
        @(negedge clock);
        check_count++;
        if (beat_valid !== 1'b1) begin
            $display("FAILED at %0d ns: beat_valid = %b, expected 1", $time, beat_valid);
            error_count++;
        end
        if (extra_trigger) begin
            pulse_trigger();  // lands while the burst is working.
        end
        wait_burst_done();
    endtask

    ////////////////////
    // comparing process
    ////////////////////

    always @(negedge clock) begin
        noise_beat_t expected;
        if (!reset) begin
            held = 1'b0;
        end else begin
            if (held) begin
                check_count++;
                if (beat_valid !== 1'b1) begin
                    $display("FAILED at %0d ns: beat_valid = %b, expected 1 while stalled",
                             $time, beat_valid);
                    error_count++;
                end
                if (beat !== held_beat) begin
                    $display("FAILED at %0d ns: beat = %h, expected %h while stalled", $time,
                             beat, held_beat);
                    error_count++;
                end
            end
            held = beat_valid && !beat_ready;
            held_beat = beat;
            if (beat_valid && beat_ready) begin
                if (beats_pending == 0) begin
                    $display("beat accepted at %0d ns with no burst in progress", $time);
                    error_count++;
                end else begin
                    expected = expected_beat(burst_length_model - beats_pending,
                                             burst_length_model);
                    check_count++;
                    if (beat.sample !== expected.sample) begin
                        $display("FAILED at %0d ns: beat.sample = %h, expected %h", $time,
                                 beat.sample, expected.sample);
                        error_count++;
                    end
                    if (beat.dest !== expected.dest) begin
                        $display("FAILED at %0d ns: beat.dest = %h, expected %h", $time,
                                 beat.dest, expected.dest);
                        error_count++;
                    end
                    if (beat.last !== expected.last) begin
                        $display("FAILED at %0d ns: beat.last = %b, expected %b", $time,
                                 beat.last, expected.last);
                        error_count++;
                    end
                    advance_model();
                    beats_pending--;
                end
            end
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial begin
        reset = 1'b0;
        trigger = 1'b0;
        reg_address = '0;
        reg_write = 1'b0;
        reg_write_data = '0;
        beat_ready = 1'b1;
        random_ready = 1'b0;
        held = 1'b0;
        stim_rng = 32'd74878;
        ready_rng = 32'd74878;
        beats_pending = 0;
        burst_length_model = 0;
        check_count = 0;
        error_count = 0;
        $readmemh("erf.mem", model_samples);
        apply_reset();

        write_register(0, 16'd5);
        read_check(0, 16'd5);
        write_register(0, 16'd20);
        read_check(0, 16'd16);
        write_register(4, 16'habcd);
        read_check(4, 16'h000d);
        write_register(20, 16'h1234);
        read_check(20, 16'h0000);  // unmapped.

        // ready held high first, then random back-pressure.
        for (int b = 0; b < 8; b++) begin
            random_ready = (b >= 3);
            configure_burst();
            run_burst(1'b0);
        end

        write_register(0, 16'd8);
        run_burst(1'b1);
        check_no_beat(10);
        write_register(0, 16'd0);
        pulse_trigger();
        check_no_beat(20);

        // generators restart from the seeds.
        random_ready = 1'b0;
        apply_reset();
        configure_burst();
        run_burst(1'b0);
        finish_run();
    end

endmodule

//--- erf.mem
// one 16-bit two's complement sample per line, table index 0 to 63.
b2a4
c06b
c79a
ccc8
d0d8
d447
d749
d9f4
dc60
de9c
e0b7
e2ac
e486
e64a
e800
e99e
eb33
ecb4
ee35
efa7
f10e
f272
f3ce
f525
f675
f7c3
f90e
fa54
fb9a
fcdd
fe1e
ff5f
00a1
01e2
0323
0466
05ac
06f2
083d
098b
0adb
0c32
0d8e
0ef2
1059
11cb
134c
14cd
1662
1800
19b6
1b7a
1d54
1f49
2164
23a0
260c
28b7
2bb9
2f28
3338
3866
3f95
4d5c
